// ==== verilog/replay_pkg.sv ====
// ####################
// Replay ingest shared definitions
// Widths, queue count, FIFO depths,
// LFSR constants and writer states
// ####################

package replay_pkg;

  // Stream side widths
  localparam int data_w = 64;
  localparam int strb_w = data_w / 8;
  localparam int user_w = 32;
  localparam int stamp_w = 32;

  // Memory line is strobe above data, read out as two halves
  localparam int line_w = data_w + strb_w;
  localparam int half_w = line_w / 2;

  // Replay queues
  localparam int num_queues = 4;
  localparam int qid_w = $clog2(num_queues);

  // Input beat buffer
  localparam int ingest_depth = 4;
  localparam int ingest_ptr_w = $clog2(ingest_depth);

  // Output line buffer
  localparam int line_depth = 16;
  localparam int line_ptr_w = $clog2(line_depth);

  // Queue selection LFSR
  localparam int lfsr_w = 32;
  localparam logic [lfsr_w-1:0] lfsr_seed = '1;
  // Feedback taps at bits 31, 6, 4, 2, 1 and 0
  localparam logic [lfsr_w-1:0] lfsr_taps = 32'h8000_0057;

  // Writer states
  typedef enum logic {
    wr_header = 1'b0,
    wr_packet = 1'b1
  } write_state_t;

endpackage

// ==== verilog/ingest_fifo.sv ====
// ####################
// Ingest FIFO
// Four-entry fall-through buffer of stream
// beats, nearly full at three entries
// ####################

`timescale 1ns/10ps

module ingest_fifo (
  input  logic                        axi_aclk,
  input  logic                        axi_aresetn,
  input  logic [replay_pkg::data_w-1:0] wr_data,
  input  logic [replay_pkg::strb_w-1:0] wr_strb,
  input  logic [replay_pkg::user_w-1:0] wr_user,
  input  logic                        wr_last,
  input  logic                        wr_en,
  input  logic                        pop,
  output logic [replay_pkg::data_w-1:0] head_data,
  output logic [replay_pkg::strb_w-1:0] head_strb,
  output logic [replay_pkg::user_w-1:0] head_user,
  output logic                        head_last,
  output logic                        head_empty,
  output logic                        nearly_full
);

  import replay_pkg::*;

  // Beat storage
  logic [data_w-1:0] data_mem [ingest_depth];
  logic [strb_w-1:0] strb_mem [ingest_depth];
  logic [user_w-1:0] user_mem [ingest_depth];
  logic              last_mem [ingest_depth];

  logic [ingest_ptr_w-1:0] wr_ptr;
  logic [ingest_ptr_w-1:0] rd_ptr;
  logic [ingest_ptr_w:0]   count;

  // Head shows straight from storage, no read delay
  assign head_data = data_mem[rd_ptr];
  assign head_strb = strb_mem[rd_ptr];
  assign head_user = user_mem[rd_ptr];
  assign head_last = last_mem[rd_ptr];
  assign head_empty = (count == '0);
  // Leaves one slot of slack for the tready loop
  assign nearly_full = (count >= (ingest_ptr_w + 1)'(ingest_depth - 1));

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= wr_data;
      strb_mem[wr_ptr] <= wr_strb;
      user_mem[wr_ptr] <= wr_user;
      last_mem[wr_ptr] <= wr_last;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy tracks both sides at once
      case ({wr_en, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Upstream tready must hold writes off a full buffer
  a_no_write_full: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    wr_en |-> (count != (ingest_ptr_w + 1)'(ingest_depth)));

  // Writer must only consume a present beat
  a_no_pop_empty: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    pop |-> !head_empty);

endmodule

// ==== verilog/write_fsm.sv ====
// ####################
// Line writer FSM
// Header line then one line per beat,
// end-of-packet marked in the queue id
// ####################

`timescale 1ns/10ps

module write_fsm (
  input  logic                          axi_aclk,
  input  logic                          axi_aresetn,
  input  logic [replay_pkg::data_w-1:0]  head_data,
  input  logic [replay_pkg::strb_w-1:0]  head_strb,
  input  logic [replay_pkg::user_w-1:0]  head_user,
  input  logic                          head_last,
  input  logic                          head_empty,
  input  logic                          line_full,
  input  logic [replay_pkg::stamp_w-1:0] timestamp,
  input  logic [replay_pkg::qid_w-1:0]   queue_sel,
  output logic                          pop,
  output logic                          line_wr,
  output logic [replay_pkg::data_w-1:0]  line_data,
  output logic [replay_pkg::strb_w-1:0]  line_strb,
  output logic [replay_pkg::qid_w-1:0]   qid_lo,
  output logic [replay_pkg::qid_w-1:0]   qid_hi
);

  import replay_pkg::*;

  write_state_t state;
  write_state_t next_state;

  // Queue id held for the whole packet
  logic [qid_w-1:0] qid_r;
  // One extra bit so a full strobe carries out
  logic [strb_w:0]  strb_sum;
  logic             line_ok;

  // A beat is waiting and there is room for its line
  assign line_ok = !head_empty && !line_full;
  assign strb_sum = {1'b0, head_strb} + 1'b1;

  always_comb begin
    next_state = state;
    pop = 1'b0;
    line_wr = 1'b0;
    line_data = head_data;
    line_strb = '0;
    qid_lo = qid_r;
    qid_hi = qid_r;
    case (state)
      wr_header: begin
        // Beat stays put, only its tuser is used here
        if (line_ok) begin
          line_wr = 1'b1;
          line_data = {timestamp, head_user};
          qid_lo = queue_sel;
          qid_hi = queue_sel;
          next_state = wr_packet;
        end
      end
      wr_packet: begin
        if (line_ok) begin
          line_wr = 1'b1;
          pop = 1'b1;
          if (head_last) begin
            // Compressed byte count of the last beat
            line_strb = strb_sum[strb_w:1];
            // Id one above the real queue flags end of packet
            qid_hi = qid_r + 1'b1;
            next_state = wr_header;
          end
        end
      end
      default: next_state = wr_header;
    endcase
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state <= wr_header;
      qid_r <= '0;
    end else begin
      state <= next_state;
      // Latch the picked queue with the header
      if (state == wr_header && line_ok) begin
        qid_r <= queue_sel;
      end
    end
  end

  // A waiting beat leaves the head only through a pop
  a_head_held: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    !head_empty && !pop |=> !head_empty);

endmodule

// ==== verilog/stamp_timer.sv ====
// ####################
// Stamp timer
// Free-running packet timestamp,
// wraps at full width
// ####################

`timescale 1ns/10ps

module stamp_timer (
  input  logic                          axi_aclk,
  input  logic                          axi_aresetn,
  output logic [replay_pkg::stamp_w-1:0] timestamp
);

  import replay_pkg::*;

  logic [stamp_w-1:0] count;

  assign timestamp = count;

  // One tick per clock
  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== verilog/queue_picker.sv ====
// ####################
// Queue picker
// LFSR against three split ratios
// selects the replay queue
// ####################

`timescale 1ns/10ps

module queue_picker (
  input  logic                         axi_aclk,
  input  logic                         axi_aresetn,
  input  logic [replay_pkg::lfsr_w-1:0] split_ratio_0,
  input  logic [replay_pkg::lfsr_w-1:0] split_ratio_1,
  input  logic [replay_pkg::lfsr_w-1:0] split_ratio_2,
  output logic [replay_pkg::qid_w-1:0]  queue_sel
);

  import replay_pkg::*;

  logic [lfsr_w-1:0] lfsr;
  logic              feedback;

  // XOR of the tapped bits
  assign feedback = ^(lfsr & lfsr_taps);

  // Shift right, feedback enters at the top
  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      lfsr <= lfsr_seed;
    end else begin
      lfsr <= {feedback, lfsr[lfsr_w-1:1]};
    end
  end

  // First threshold the LFSR does not exceed wins
  always_comb begin
    if (lfsr <= split_ratio_0) begin
      queue_sel = qid_w'(0);
    end else if (lfsr <= split_ratio_1) begin
      queue_sel = qid_w'(1);
    end else if (lfsr <= split_ratio_2) begin
      queue_sel = qid_w'(2);
    end else begin
      queue_sel = qid_w'(3);
    end
  end

  // Seeded nonzero, the taps must keep it off the lockup state
  a_lfsr_nonzero: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    lfsr != '0);

endmodule

// ==== verilog/line_fifo.sv ====
// ####################
// Line FIFO
// Sixteen memory lines with two queue ids,
// read out as low half then high half
// ####################

`timescale 1ns/10ps

module line_fifo (
  input  logic                         axi_aclk,
  input  logic                         axi_aresetn,
  input  logic                         line_wr,
  input  logic [replay_pkg::data_w-1:0] line_data,
  input  logic [replay_pkg::strb_w-1:0] line_strb,
  input  logic [replay_pkg::qid_w-1:0]  qid_lo,
  input  logic [replay_pkg::qid_w-1:0]  qid_hi,
  input  logic                         rd_en,
  output logic                         line_full,
  output logic [replay_pkg::half_w-1:0] dout,
  output logic [replay_pkg::qid_w-1:0]  dout_qid,
  output logic                         empty
);

  import replay_pkg::*;

  // Packed lines, strobe above data
  logic [line_w-1:0] line_mem [line_depth];
  logic [qid_w-1:0]  qlo_mem [line_depth];
  logic [qid_w-1:0]  qhi_mem [line_depth];

  logic [line_ptr_w-1:0] wr_ptr;
  logic [line_ptr_w-1:0] rd_ptr;
  logic [line_ptr_w:0]   count;
  // Low when the low half is on the output
  logic                  half_sel;
  logic [line_w-1:0]     head_line;
  logic                  free;

  assign head_line = line_mem[rd_ptr];

  // Pick half and its id
  assign dout = half_sel ? head_line[line_w-1:half_w] : head_line[half_w-1:0];
  assign dout_qid = half_sel ? qhi_mem[rd_ptr] : qlo_mem[rd_ptr];

  assign empty = (count == '0);
  assign line_full = (count == (line_ptr_w + 1)'(line_depth));
  // Second half read releases the line
  assign free = rd_en && half_sel;

  always_ff @(posedge axi_aclk) begin
    if (line_wr) begin
      line_mem[wr_ptr] <= {line_strb, line_data};
      qlo_mem[wr_ptr] <= qid_lo;
      qhi_mem[wr_ptr] <= qid_hi;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      half_sel <= 1'b0;
    end else begin
      if (line_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        half_sel <= !half_sel;
      end
      if (free) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Count whole lines only
      case ({line_wr, free})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Writer has to respect back-pressure
  a_no_write_full: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    line_wr |-> !line_full);

  // Downstream reads only while data is shown
  a_no_read_empty: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    rd_en |-> !empty);

endmodule

// ==== verilog/replay_ingest_top.sv ====
// ####################
// Replay ingest top
// AXI-Stream packets to tagged memory
// line halves for the replay queues
// ####################

`timescale 1ns/10ps

module replay_ingest_top (
  input  logic                         axi_aclk,
  input  logic                         axi_aresetn,
  input  logic [replay_pkg::data_w-1:0] s_axis_tdata,
  input  logic [replay_pkg::strb_w-1:0] s_axis_tstrb,
  input  logic [replay_pkg::user_w-1:0] s_axis_tuser,
  input  logic                         s_axis_tvalid,
  input  logic                         s_axis_tlast,
  output logic                         s_axis_tready,
  input  logic                         fifo_rd_en,
  output logic [replay_pkg::half_w-1:0] fifo_dout,
  output logic [replay_pkg::qid_w-1:0]  fifo_dout_qid,
  output logic                         fifo_empty,
  input  logic [replay_pkg::lfsr_w-1:0] split_ratio_0,
  input  logic [replay_pkg::lfsr_w-1:0] split_ratio_1,
  input  logic [replay_pkg::lfsr_w-1:0] split_ratio_2
);

  import replay_pkg::*;

  // Ingest FIFO head
  logic [data_w-1:0]  ififo_data;
  logic [strb_w-1:0]  ififo_strb;
  logic [user_w-1:0]  ififo_user;
  logic               ififo_last;
  logic               ififo_empty;
  logic               ififo_nearly_full;
  logic               ififo_pop;

  // Writer to line FIFO
  logic               line_wr;
  logic [data_w-1:0]  line_data;
  logic [strb_w-1:0]  line_strb;
  logic [qid_w-1:0]   qid_lo;
  logic [qid_w-1:0]   qid_hi;
  logic               line_full;

  logic [stamp_w-1:0] timestamp;
  logic [qid_w-1:0]   queue_sel;
  logic               beat_wr;

  // Accept while the ingest FIFO has slack
  assign s_axis_tready = !ififo_nearly_full;
  assign beat_wr = s_axis_tvalid && s_axis_tready;

  ingest_fifo u_ingest_fifo (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .wr_data     (s_axis_tdata),
    .wr_strb     (s_axis_tstrb),
    .wr_user     (s_axis_tuser),
    .wr_last     (s_axis_tlast),
    .wr_en       (beat_wr),
    .pop         (ififo_pop),
    .head_data   (ififo_data),
    .head_strb   (ififo_strb),
    .head_user   (ififo_user),
    .head_last   (ififo_last),
    .head_empty  (ififo_empty),
    .nearly_full (ififo_nearly_full)
  );

  write_fsm u_write_fsm (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .head_data   (ififo_data),
    .head_strb   (ififo_strb),
    .head_user   (ififo_user),
    .head_last   (ififo_last),
    .head_empty  (ififo_empty),
    .line_full   (line_full),
    .timestamp   (timestamp),
    .queue_sel   (queue_sel),
    .pop         (ififo_pop),
    .line_wr     (line_wr),
    .line_data   (line_data),
    .line_strb   (line_strb),
    .qid_lo      (qid_lo),
    .qid_hi      (qid_hi)
  );

  stamp_timer u_stamp_timer (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .timestamp   (timestamp)
  );

  queue_picker u_queue_picker (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .split_ratio_0 (split_ratio_0),
    .split_ratio_1 (split_ratio_1),
    .split_ratio_2 (split_ratio_2),
    .queue_sel     (queue_sel)
  );

  line_fifo u_line_fifo (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .line_wr     (line_wr),
    .line_data   (line_data),
    .line_strb   (line_strb),
    .qid_lo      (qid_lo),
    .qid_hi      (qid_hi),
    .rd_en       (fifo_rd_en),
    .line_full   (line_full),
    .dout        (fifo_dout),
    .dout_qid    (fifo_dout_qid),
    .empty       (fifo_empty)
  );

endmodule

// ==== verification/tb_clock.sv ====
// ####################
// Testbench clock and reset
// 100 ns clock, reset low for 3 cycles
// ####################

`timescale 1ns/10ps

module tb_clock (
  output logic axi_aclk,
  output logic axi_aresetn
);

  initial begin
    axi_aclk = 1'b0;
    forever #50 axi_aclk = ~axi_aclk;
  end

  // Released on a falling edge, clear of the sampling edge
  initial begin
    axi_aresetn = 1'b0;
    repeat (3) @(posedge axi_aclk);
    @(negedge axi_aclk);
    axi_aresetn = 1'b1;
  end

endmodule

// ==== verification/tb_replay_ingest.sv ====
// ####################
// Replay ingest testbench
// Directed packets through the DUT,
// output halves checked against a line model
// ####################

`timescale 1ns/10ps

module tb_replay_ingest;

  import replay_pkg::*;

  // Kinds of expected output half
  localparam logic [1:0] kind_hdr_lo = 2'd0;
  localparam logic [1:0] kind_hdr_hi = 2'd1;
  localparam logic [1:0] kind_data = 2'd2;
  localparam int wait_limit = 200;
  // Cycles of steady low tready that mean a full line FIFO
  localparam int stall_run = 3;
  // Header fields inside a half
  localparam logic [half_w-1:0] user_mask = {{(half_w-user_w){1'b0}}, {user_w{1'b1}}};
  localparam logic [half_w-1:0] strb_mask = {{strb_w{1'b1}}, {(half_w-strb_w){1'b0}}};

  logic                     axi_aclk;
  logic                     axi_aresetn;
  logic [data_w-1:0]        s_axis_tdata;
  logic [strb_w-1:0]        s_axis_tstrb;
  logic [user_w-1:0]        s_axis_tuser;
  logic                     s_axis_tvalid;
  logic                     s_axis_tlast;
  logic                     s_axis_tready;
  logic                     fifo_rd_en;
  logic [half_w-1:0]        fifo_dout;
  logic [qid_w-1:0]         fifo_dout_qid;
  logic                     fifo_empty;
  logic [lfsr_w-1:0]        split_ratio_0;
  logic [lfsr_w-1:0]        split_ratio_1;
  logic [lfsr_w-1:0]        split_ratio_2;

  // Line model, one entry per output half
  logic [1:0]               exp_kind [$];
  logic [half_w-1:0]        exp_half [$];
  logic [qid_w-1:0]         exp_qid [$];

  logic [31:0]              lcg_state = 32'h8adf_e78f;
  logic [stamp_w-1:0]       cycle_count;
  logic [stamp_w-1:0]       last_stamp;
  logic                     have_stamp;
  logic [half_w-user_w-1:0] stamp_nibble;
  int                       checks;
  int                       errors;
  int                       timeouts;

  tb_clock u_clock (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn)
  );

  replay_ingest_top dut (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .fifo_rd_en    (fifo_rd_en),
    .fifo_dout     (fifo_dout),
    .fifo_dout_qid (fifo_dout_qid),
    .fifo_empty    (fifo_empty),
    .split_ratio_0 (split_ratio_0),
    .split_ratio_1 (split_ratio_1),
    .split_ratio_2 (split_ratio_2)
  );

  // Same count as the timestamp, upper bound for header stamps
  always @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Last beat strobe, (strobe + 1) >> 1 on 9 bits
  function automatic logic [strb_w-1:0] end_strobe(input logic [strb_w-1:0] strb);
    logic [strb_w:0] wide;
    wide = {1'b0, strb} + 1'b1;
    wide = wide >> 1;
    return wide[strb_w-1:0];
  endfunction

  task automatic compare_half(input string name, input logic [half_w-1:0] got,
                              input logic [half_w-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic compare_qid(input string name, input logic [qid_w-1:0] got,
                             input logic [qid_w-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  // Stamps rise packet to packet and never run ahead of the clock
  task automatic check_stamp(input logic [stamp_w-1:0] stamp);
    checks++;
    if (have_stamp && stamp <= last_stamp) begin
      errors++;
      $display("Fail header timestamp: got 0x%h, previous 0x%h", stamp, last_stamp);
    end
    if (stamp >= cycle_count) begin
      errors++;
      $display("Fail header timestamp: got 0x%h, cycle count 0x%h", stamp, cycle_count);
    end
    last_stamp = stamp;
    have_stamp = 1'b1;
  endtask

  task automatic push_expected(input logic [1:0] kind, input logic [half_w-1:0] value,
                               input logic [qid_w-1:0] qid);
    exp_kind.push_back(kind);
    exp_half.push_back(value);
    exp_qid.push_back(qid);
  endtask

  // Checks the half now on the output against the model head
  task automatic check_output_half();
    logic [1:0]         kind;
    logic [half_w-1:0]  value;
    logic [qid_w-1:0]   qid;
    logic [stamp_w-1:0] stamp;
    if (exp_kind.size() == 0) begin
      errors++;
      $display("Output half 0x%h appeared with nothing left to expect", fifo_dout);
    end else begin
      kind = exp_kind.pop_front();
      value = exp_half.pop_front();
      qid = exp_qid.pop_front();
      compare_qid("fifo_dout_qid", fifo_dout_qid, qid);
      case (kind)
        kind_hdr_lo: begin
          compare_half("fifo_dout header tuser", fifo_dout & user_mask, value);
          stamp_nibble = fifo_dout[half_w-1:user_w];
        end
        kind_hdr_hi: begin
          compare_half("fifo_dout header strobe", fifo_dout & strb_mask, value);
          // Stamp low nibble came with the low half
          stamp = {fifo_dout[half_w-strb_w-1:0], stamp_nibble};
          check_stamp(stamp);
        end
        default: compare_half("fifo_dout", fifo_dout, value);
      endcase
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic send_beat(input logic [data_w-1:0] data, input logic [strb_w-1:0] strb,
                           input logic [user_w-1:0] user, input logic last);
    int waits;
    waits = 0;
    s_axis_tdata = data;
    s_axis_tstrb = strb;
    s_axis_tuser = user;
    s_axis_tlast = last;
    s_axis_tvalid = 1'b1;
    while (!s_axis_tready && waits < wait_limit) begin
      @(negedge axi_aclk);
      waits++;
    end
    if (!s_axis_tready) begin
      timeouts++;
      $display("Timeout: tready stayed low and a beat was dropped");
    end
    // Transfer on the rising edge in between
    @(negedge axi_aclk);
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
  endtask

  // Models the packet's halves first, then drives its beats
  task automatic send_packet(input logic [user_w-1:0] user, input int beats,
                             input logic [strb_w-1:0] last_strb, input logic [qid_w-1:0] qid);
    logic [data_w-1:0] beat_data [$];
    logic [31:0]       word_hi;
    logic [31:0]       word_lo;
    logic [strb_w-1:0] line_strb;
    logic [qid_w-1:0]  end_qid;
    int                i;
    push_expected(kind_hdr_lo, {{(half_w-user_w){1'b0}}, user}, qid);
    push_expected(kind_hdr_hi, '0, qid);
    for (i = 0; i < beats; i++) begin
      word_hi = lcg_next();
      word_lo = lcg_next();
      beat_data.push_back({word_hi, word_lo});
      line_strb = '0;
      end_qid = qid;
      if (i == beats - 1) begin
        line_strb = end_strobe(last_strb);
        end_qid = qid + 1'b1;
      end
      push_expected(kind_data, beat_data[i][half_w-1:0], qid);
      push_expected(kind_data, {line_strb, beat_data[i][data_w-1:half_w]}, end_qid);
    end
    for (i = 0; i < beats; i++) begin
      if (i == beats - 1) begin
        send_beat(beat_data[i], last_strb, user, 1'b1);
      end else begin
        send_beat(beat_data[i], '1, user, 1'b0);
      end
    end
  endtask

  // Pops one half per cycle while the output is not empty
  task automatic read_halves(input int count);
    int got;
    int idle;
    got = 0;
    idle = 0;
    while (got < count && idle < wait_limit) begin
      if (!fifo_empty) begin
        check_output_half();
        fifo_rd_en = 1'b1;
        got++;
        idle = 0;
      end else begin
        fifo_rd_en = 1'b0;
        idle++;
      end
      @(negedge axi_aclk);
    end
    fifo_rd_en = 1'b0;
    if (got < count) begin
      timeouts++;
      $display("Timeout: only %0d of %0d output halves arrived", got, count);
    end else begin
      compare_bit("fifo_empty", fifo_empty, 1'b1);
    end
  endtask

  // A header holds tready low for one cycle only, so wait for a steady low
  task automatic wait_for_stall();
    int waits;
    int low_run;
    waits = 0;
    low_run = 0;
    while (low_run < stall_run && waits < wait_limit) begin
      @(negedge axi_aclk);
      waits++;
      if (!s_axis_tready) begin
        low_run++;
      end else begin
        low_run = 0;
      end
    end
    if (low_run < stall_run) begin
      timeouts++;
      $display("Timeout: tready never stayed low under back-pressure");
    end
  endtask

  task automatic reset_state_test();
    $display("Test: reset state");
    compare_bit("fifo_empty", fifo_empty, 1'b1);
    compare_bit("s_axis_tready", s_axis_tready, 1'b1);
  endtask

  task automatic single_beat_test();
    $display("Test: single-beat packets to queue 0");
    split_ratio_0 = '1;
    split_ratio_1 = '1;
    split_ratio_2 = '1;
    // Full strobe ends as 80 hex
    send_packet(32'h5eed_0001, 1, 8'hff, 2'd0);
    read_halves(4);
    send_packet(32'h1234_5678, 1, 8'h0f, 2'd0);
    read_halves(4);
  endtask

  task automatic multi_beat_test();
    $display("Test: multi-beat packets to queue 3");
    split_ratio_0 = '0;
    split_ratio_1 = '0;
    split_ratio_2 = '0;
    send_packet(32'h0bad_0003, 4, 8'h3f, 2'd3);
    read_halves(10);
    send_packet(32'h7777_0303, 3, 8'h01, 2'd3);
    read_halves(8);
  endtask

  task automatic queue_select_test();
    $display("Test: queue 1 and queue 2 selection");
    split_ratio_0 = '0;
    split_ratio_1 = '1;
    split_ratio_2 = '1;
    send_packet(32'h0000_0101, 2, 8'h7f, 2'd1);
    read_halves(6);
    send_packet(32'h0000_0102, 1, 8'hff, 2'd1);
    read_halves(4);
    split_ratio_1 = '0;
    send_packet(32'h0000_0201, 2, 8'h03, 2'd2);
    read_halves(6);
    send_packet(32'h0000_0202, 3, 8'hff, 2'd2);
    read_halves(8);
  endtask

  // Five packets fill both FIFOs before any read starts
  task automatic back_pressure_test();
    $display("Test: back-pressure with five packets in flight");
    split_ratio_0 = '0;
    split_ratio_1 = '0;
    split_ratio_2 = '1;
    fork
      begin
        send_packet(32'hb0b0_0001, 4, 8'hff, 2'd2);
        send_packet(32'hb0b0_0002, 4, 8'h01, 2'd2);
        send_packet(32'hb0b0_0003, 4, 8'h1f, 2'd2);
        send_packet(32'hb0b0_0004, 4, 8'hff, 2'd2);
        send_packet(32'hb0b0_0005, 4, 8'h07, 2'd2);
      end
      begin
        wait_for_stall();
        read_halves(50);
      end
    join
  endtask

  initial begin
    int waits;
    s_axis_tdata = '0;
    s_axis_tstrb = '0;
    s_axis_tuser = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    fifo_rd_en = 1'b0;
    split_ratio_0 = '0;
    split_ratio_1 = '0;
    split_ratio_2 = '0;
    checks = 0;
    errors = 0;
    timeouts = 0;
    have_stamp = 1'b0;
    last_stamp = '0;
    stamp_nibble = '0;
    waits = 0;
    while (axi_aresetn !== 1'b1 && waits < wait_limit) begin
      @(negedge axi_aclk);
      waits++;
    end
    if (axi_aresetn !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    @(negedge axi_aclk);
    reset_state_test();
    single_beat_test();
    multi_beat_test();
    queue_select_test();
    back_pressure_test();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/replay_pkg.sv
verilog/ingest_fifo.sv
verilog/write_fsm.sv
verilog/stamp_timer.sv
verilog/queue_picker.sv
verilog/line_fifo.sv
verilog/replay_ingest_top.sv
verification/tb_clock.sv
verification/tb_replay_ingest.sv

// ==== Makefile ====
# Verilator build and run of the replay ingest testbench

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_replay_ingest -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_replay_ingest | tee sim.log
	! grep -q ">>> FAIL" sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
